/* logic/uartPkg.sv */
package uartPkg;

        //////////////////////////////////////////////////
        // Bit timing

        parameter int OVERSAMPLE = 16;          // Ticks per bit period

        //////////////////////////////////////////////////
        // FSM encodings

        // Deserializer steps through one frame
        typedef enum logic [2:0] {
                IDLE,
                START,
                DATA,
                PARITY,
                STOP
        } rxState_t;

        typedef enum logic [1:0] {
                OFF,                            // Self-test idle
                SEND,                           // Shifting a frame onto the loopback
                WAIT,                           // Waiting for the byte to come back
                DONE                            // Result held until bistMode drops
        } bistState_t;

        //////////////////////////////////////////////////
        // Self-test constants

        parameter int         BIST_FRAMES = 8;          // Bytes per self-test run
        parameter logic [7:0] BIST_SEED   = 8'h5A;      // Byte LFSR start value

endpackage

/* logic/rxByteIf.sv */
`timescale 1ns/1ps

interface rxByteIf
#(
        parameter int dataBits = 8
);

        logic [dataBits-1:0] data;      // Received byte
        logic                strobe;    // One-cycle valid pulse
        logic                frameErr;  // Stop bit was low
        logic                parityErr; // Even parity mismatch

        // Deserializer side
        modport src (output data, output strobe, output frameErr, output parityErr);

        // FIFO and self-test side
        modport snk (input data, input strobe, input frameErr, input parityErr);

endinterface

/* logic/baudTicker.sv */
`timescale 1ns/1ps

module baudTicker
#(
        parameter int clkDiv = 4
)
(
        input  logic clk,
        input  logic rst,
        output logic tick
);

        localparam int cntW = (clkDiv > 1) ? $clog2(clkDiv) : 1;

        logic [cntW-1:0] divCnt;                // Clocks since last tick
        logic            wrap;

        assign wrap = (divCnt == cntW'(clkDiv - 1));

        // Free-running divider, tick is registered
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        divCnt <= '0;
                        tick   <= 1'b0;
                end
                else
                begin
                        if (wrap)
                                divCnt <= '0;
                        else
                                divCnt <= divCnt + 1'b1;
                        tick <= wrap;           // One pulse per clkDiv clocks
                end
        end

endmodule

/* logic/uartRx.sv */
`timescale 1ns/1ps

module uartRx import uartPkg::*;
#(
        parameter int dataBits = 8,
        parameter int parityEn = 1
)
(
        input  logic clk,
        input  logic rst,
        input  logic tick,
        input  logic serialLine,
        rxByteIf.src rxOut
);

        localparam int tickW = $clog2(OVERSAMPLE);
        localparam int bitW  = (dataBits > 1) ? $clog2(dataBits) : 1;

        rxState_t            state;
        logic [1:0]          syncQ;             // Two-flop synchronizer
        logic                lineS;             // Synced line level
        logic                lineD;             // Previous synced level
        logic [tickW-1:0]    tickCnt;           // Ticks into current bit
        logic [bitW-1:0]     bitCnt;            // Data bits taken so far
        logic [dataBits-1:0] shiftReg;          // LSB arrives first
        logic                parErr;            // Held until the stop bit
        logic                halfPoint;
        logic                bitPoint;

        assign lineS     = syncQ[1];
        assign halfPoint = tick && (tickCnt == tickW'(OVERSAMPLE / 2 - 1));
        assign bitPoint  = tick && (tickCnt == tickW'(OVERSAMPLE - 1));

        // Byte is stable from the last data bit until the next frame
        assign rxOut.data = shiftReg;

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        syncQ <= 2'b11;         // Line idles high
                        lineD <= 1'b1;
                end
                else
                begin
                        syncQ <= {syncQ[0], serialLine};
                        lineD <= lineS;
                end
        end

        //////////////////////////////////////////////////
        // Frame FSM

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        state           <= IDLE;
                        tickCnt         <= '0;
                        bitCnt          <= '0;
                        parErr          <= 1'b0;
                        rxOut.strobe    <= 1'b0;
                        rxOut.frameErr  <= 1'b0;
                        rxOut.parityErr <= 1'b0;
                end
                else
                begin
                        rxOut.strobe    <= 1'b0;        // Pulses only
                        rxOut.frameErr  <= 1'b0;
                        rxOut.parityErr <= 1'b0;
                        if (tick)
                                tickCnt <= tickCnt + 1'b1;
                        case (state)
                        IDLE:
                        begin
                                tickCnt <= '0;
                                bitCnt  <= '0;
                                if (lineD && !lineS)
                                        state <= START; // Falling edge
                        end
                        START:
                        begin
                                if (halfPoint)
                                begin
                                        tickCnt <= '0;
                                        // High again at mid start means a glitch
                                        state   <= lineS ? IDLE : DATA;
                                end
                        end
                        DATA:
                        begin
                                if (bitPoint)
                                begin
                                        tickCnt  <= '0;
                                        shiftReg <= {lineS, shiftReg[dataBits-1:1]};
                                        bitCnt   <= bitCnt + 1'b1;
                                        if (bitCnt == bitW'(dataBits - 1))
                                                state <= (parityEn != 0) ? PARITY : STOP;
                                end
                        end
                        PARITY:
                        begin
                                if (bitPoint)
                                begin
                                        tickCnt <= '0;
                                        parErr  <= (lineS != ^shiftReg);   // Even parity
                                        state   <= STOP;
                                end
                        end
                        STOP:
                        begin
                                if (bitPoint)
                                begin
                                        rxOut.strobe    <= 1'b1;
                                        rxOut.frameErr  <= !lineS;
                                        rxOut.parityErr <= parErr;
                                        parErr          <= 1'b0;
                                        state           <= IDLE;
                                end
                        end
                        default:
                                state <= IDLE;
                        endcase
                end
        end

        // Each byte is reported in exactly one cycle
        strobeSingle: assert property (@(posedge clk) disable iff (rst)
                rxOut.strobe |=> !rxOut.strobe);

endmodule

/* logic/rxFifo.sv */
`timescale 1ns/1ps

module rxFifo
#(
        parameter int dataBits  = 8,
        parameter int fifoWidth = 4
)
(
        input  logic                clk,
        input  logic                rst,
        rxByteIf.snk                rxIn,
        input  logic                pop,
        input  logic                bistMode,
        output logic                empty,
        output logic                halfFull,
        output logic                full,
        output logic                overflow,
        output logic [dataBits-1:0] dataOut
);

        localparam int entries = 2 ** fifoWidth;

        logic [dataBits-1:0]  fifoMem [entries];
        logic [fifoWidth-1:0] rdPtr;
        logic [fifoWidth-1:0] wrPtr;
        logic [fifoWidth:0]   count;            // One bit wider than pointers
        logic [fifoWidth:0]   countNext;
        logic                 wrReq;
        logic                 popReq;
        logic                 doWrite;
        logic                 doPop;

        // Only clean bytes, nothing while self-test owns the line
        assign wrReq   = !bistMode && rxIn.strobe && !rxIn.frameErr && !rxIn.parityErr;
        assign popReq  = !bistMode && pop && !wrReq;    // Write wins over pop
        assign doWrite = wrReq && (count != (fifoWidth + 1)'(entries));
        assign doPop   = popReq && (count != '0);       // Empty pop is ignored

        assign countNext = count + (fifoWidth + 1)'(doWrite) - (fifoWidth + 1)'(doPop);

        always_ff @(posedge clk)
        begin
                if (doWrite)
                        fifoMem[wrPtr] <= rxIn.data;
        end

        //////////////////////////////////////////////////
        // Pointers and flags

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        rdPtr    <= '0;
                        wrPtr    <= '0;
                        count    <= '0;
                        empty    <= 1'b1;
                        halfFull <= 1'b0;
                        full     <= 1'b0;
                        overflow <= 1'b0;
                        dataOut  <= '0;
                end
                else
                begin
                        count    <= countNext;
                        empty    <= (countNext == '0);
                        halfFull <= (countNext >= (fifoWidth + 1)'(entries / 2));
                        full     <= (countNext == (fifoWidth + 1)'(entries));
                        if (doWrite)
                                wrPtr <= wrPtr + 1'b1;
                        if (wrReq && !doWrite)
                                overflow <= 1'b1;       // Byte lost, sticky
                        if (doPop)
                        begin
                                dataOut  <= fifoMem[rdPtr];     // Oldest byte
                                rdPtr    <= rdPtr + 1'b1;
                                overflow <= 1'b0;
                        end
                end
        end

        countBound: assert property (@(posedge clk) disable iff (rst)
                count <= (fifoWidth + 1)'(entries));

        flagsExclusive: assert property (@(posedge clk) disable iff (rst)
                !(full && empty));

endmodule

/* logic/bistEngine.sv */
`timescale 1ns/1ps

module bistEngine import uartPkg::*;
#(
        parameter int dataBits = 8,
        parameter int parityEn = 1
)
(
        input  logic clk,
        input  logic rst,
        input  logic tick,
        input  logic bistMode,
        input  logic rxLine,
        output logic serialLine,
        rxByteIf.snk rxIn,
        output logic bistDone,
        output logic bistPass
);

        localparam int frameW   = dataBits + 3;         // Start, data, parity, stop
        localparam int stopIdx  = (parityEn != 0) ? dataBits + 2 : dataBits + 1;
        localparam int tickW    = $clog2(OVERSAMPLE);
        localparam int bitW     = $clog2(frameW);
        localparam int toTicks  = 2 * frameW * OVERSAMPLE;      // Two frame times
        localparam int toW      = $clog2(toTicks + 1);
        localparam int frmW     = $clog2(BIST_FRAMES + 1);

        bistState_t          state;
        logic [7:0]          lfsr;              // Byte generator
        logic [7:0]          lfsrNext;
        logic [frameW-1:0]   txShift;           // Bit 0 is on the line
        logic [tickW-1:0]    tickCnt;
        logic [bitW-1:0]     bitCnt;            // Bits already sent
        logic [toW-1:0]      toCnt;             // Return timeout
        logic [frmW-1:0]     frameCnt;
        logic                passFlag;
        logic [dataBits-1:0] txByte;            // Byte expected back
        logic                bitPoint;
        logic                timedOut;
        logic                byteBad;

        // LSB first, stop bit last
        function automatic logic [frameW-1:0] buildFrame(input logic [dataBits-1:0] b);
                if (parityEn != 0)
                        buildFrame = {1'b1, ^b, b, 1'b0};
                else
                        buildFrame = {2'b11, b, 1'b0};  // Extra idle bit
        endfunction

        assign lfsrNext = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        assign txByte   = dataBits'(lfsr);
        assign bitPoint = tick && (tickCnt == tickW'(OVERSAMPLE - 1));
        assign timedOut = tick && (toCnt == toW'(toTicks - 1));
        assign byteBad  = rxIn.frameErr || rxIn.parityErr || (rxIn.data != txByte);

        // Loopback mux, stop level outside SEND
        assign serialLine = bistMode ? ((state == SEND) ? txShift[0] : 1'b1) : rxLine;

        assign bistDone = (state == DONE);
        assign bistPass = bistDone && passFlag;

        //////////////////////////////////////////////////
        // Self-test FSM

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        state    <= OFF;
                        passFlag <= 1'b0;
                        frameCnt <= '0;
                        tickCnt  <= '0;
                        bitCnt   <= '0;
                        toCnt    <= '0;
                end
                else if (!bistMode)
                        state <= OFF;           // Results drop with bistMode
                else
                begin
                        case (state)
                        OFF:
                        begin
                                lfsr     <= BIST_SEED;
                                txShift  <= buildFrame(dataBits'(BIST_SEED));
                                passFlag <= 1'b1;
                                frameCnt <= '0;
                                tickCnt  <= '0;
                                bitCnt   <= '0;
                                state    <= SEND;
                        end
                        SEND:
                        begin
                                if (rxIn.strobe)
                                        passFlag <= 1'b0;       // Byte nobody sent
                                if (tick)
                                        tickCnt <= tickCnt + 1'b1;
                                if (bitPoint)
                                begin
                                        tickCnt <= '0;
                                        txShift <= {1'b1, txShift[frameW-1:1]};
                                        bitCnt  <= bitCnt + 1'b1;
                                        if (bitCnt == bitW'(stopIdx - 1))
                                        begin
                                                toCnt <= '0;
                                                state <= WAIT;  // Stop bit now on line
                                        end
                                end
                        end
                        WAIT:
                        begin
                                if (tick)
                                        toCnt <= toCnt + 1'b1;
                                if (rxIn.strobe || timedOut)
                                begin
                                        if (!rxIn.strobe || byteBad)
                                                passFlag <= 1'b0;
                                        lfsr     <= lfsrNext;
                                        txShift  <= buildFrame(dataBits'(lfsrNext));
                                        tickCnt  <= '0;
                                        bitCnt   <= '0;
                                        frameCnt <= frameCnt + 1'b1;
                                        if (frameCnt == frmW'(BIST_FRAMES - 1))
                                                state <= DONE;
                                        else
                                                state <= SEND;
                                end
                        end
                        default:
                                state <= DONE;  // Hold until bistMode falls
                        endcase
                end
        end

endmodule

/* logic/uartRxTop.sv */
`timescale 1ns/1ps

module uartRxTop
#(
        parameter int dataBits  = 8,
        parameter int fifoWidth = 4,            // 16 entries
        parameter int clkDiv    = 4,            // Clocks per oversample tick
        parameter int parityEn  = 1
)
(
        input  logic                clk,
        input  logic                rst,
        input  logic                rxLine,
        input  logic                pop,
        input  logic                bistMode,
        output logic [dataBits-1:0] dataOut,
        output logic                empty,
        output logic                halfFull,
        output logic                full,
        output logic                overflow,
        output logic                frameErr,
        output logic                parityErr,
        output logic                bistDone,
        output logic                bistPass
);

        logic tick;
        logic serialLine;                       // rxLine or self-test frames

        rxByteIf #(.dataBits(dataBits)) rxBus ();

        baudTicker #(.clkDiv(clkDiv)) ticker (
                .clk  (clk),
                .rst  (rst),
                .tick (tick)
        );

        uartRx #(.dataBits(dataBits), .parityEn(parityEn)) rx (
                .clk        (clk),
                .rst        (rst),
                .tick       (tick),
                .serialLine (serialLine),
                .rxOut      (rxBus.src)
        );

        rxFifo #(.dataBits(dataBits), .fifoWidth(fifoWidth)) fifo (
                .clk      (clk),
                .rst      (rst),
                .rxIn     (rxBus.snk),
                .pop      (pop),
                .bistMode (bistMode),
                .empty    (empty),
                .halfFull (halfFull),
                .full     (full),
                .overflow (overflow),
                .dataOut  (dataOut)
        );

        bistEngine #(.dataBits(dataBits), .parityEn(parityEn)) bist (
                .clk        (clk),
                .rst        (rst),
                .tick       (tick),
                .bistMode   (bistMode),
                .rxLine     (rxLine),
                .serialLine (serialLine),
                .rxIn       (rxBus.snk),
                .bistDone   (bistDone),
                .bistPass   (bistPass)
        );

        // Error pulses only with a received byte
        assign frameErr  = rxBus.strobe & rxBus.frameErr;
        assign parityErr = rxBus.strobe & rxBus.parityErr;

endmodule

/* testbench/uartRxTb.sv */
`timescale 1ns/1ps

module uartRxTb import uartPkg::*;
();

        localparam int clkDiv     = 4;
        localparam int bitClks    = OVERSAMPLE * clkDiv;       // 64 clocks per serial bit
        localparam int entries    = 16;
        localparam int numRows    = 21;
        localparam int preRows    = 20;                         // Rows before the self-test
        localparam int cycleLimit = (numRows + BIST_FRAMES) * 12 * bitClks + 2000;

        // One serial frame and the pops that follow it
        typedef struct packed {
                logic [7:0] data;
                logic       badStop;
                logic       badPar;
                logic [4:0] pops;
        } stimRow_t;

        logic        clk = 1'b0;
        logic        rst;
        logic        rxLine;
        logic        pop;
        logic        bistMode;
        logic [7:0]  dataOut;
        logic        empty;
        logic        halfFull;
        logic        full;
        logic        overflow;
        logic        frameErr;
        logic        parityErr;
        logic        bistDone;
        logic        bistPass;

        stimRow_t    rows [numRows];
        logic [7:0]  modelQ [$];                // Reference FIFO contents
        logic [7:0]  expData;
        logic        expOverflow;
        int          expFrameErrs;
        int          expParErrs;
        int          frameErrSeen = 0;
        int          parErrSeen   = 0;
        int          cycles       = 0;
        logic [31:0] lfsrState;                 // Gap generator

        uartRxTop #(.dataBits(8), .fifoWidth(4), .clkDiv(clkDiv), .parityEn(1)) dut (
                .clk       (clk),
                .rst       (rst),
                .rxLine    (rxLine),
                .pop       (pop),
                .bistMode  (bistMode),
                .dataOut   (dataOut),
                .empty     (empty),
                .halfFull  (halfFull),
                .full      (full),
                .overflow  (overflow),
                .frameErr  (frameErr),
                .parityErr (parityErr),
                .bistDone  (bistDone),
                .bistPass  (bistPass)
        );

        always #10 clk = ~clk;                  // 20 ns period

        // Error pulse tally and run limit
        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (frameErr)
                        frameErrSeen <= frameErrSeen + 1;
                if (parityErr)
                        parErrSeen <= parErrSeen + 1;
                if (cycles > cycleLimit)
                begin
                        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
                        $display("*** FAILED ***");
                        $fatal(1);
                end
        end

        //////////////////////////////////////////////////
        // Helpers

        function automatic logic [31:0] lfsrStep(input logic [31:0] s);
                lfsrStep = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32 22 2 1
        endfunction

        task automatic checkValue(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
                if (got !== want)
                begin
                        $display("Mismatch %s: got %h, expected %h", name, got, want);
                        $display("*** FAILED ***");
                        $fatal(1);
                end
        endtask

        // Flags and dataOut against the queue model
        task automatic matchModel();
                checkValue("empty", 32'(empty), 32'(modelQ.size() == 0));
                checkValue("halfFull", 32'(halfFull), 32'(modelQ.size() >= entries / 2));
                checkValue("full", 32'(full), 32'(modelQ.size() == entries));
                checkValue("overflow", 32'(overflow), 32'(expOverflow));
                checkValue("dataOut", 32'(dataOut), 32'(expData));
        endtask

        task automatic tallyErrPulses();
                checkValue("frameErr pulses", 32'(frameErrSeen), 32'(expFrameErrs));
                checkValue("parityErr pulses", 32'(parErrSeen), 32'(expParErrs));
        endtask

        // Start, 8 data LSB first, even parity, stop
        task automatic sendFrame(input logic [7:0] b, input logic badStop, input logic badPar);
                logic [10:0] bits;
                bits = {!badStop, (^b) ^ badPar, b, 1'b0};
                for (int i = 0; i < 11; i++)
                begin
                        @(posedge clk);
                        rxLine <= bits[i];
                        repeat (bitClks - 1) @(posedge clk);
                end
                @(posedge clk);
                rxLine <= 1'b1;                 // Back to idle
        endtask

        // frozen means the FIFO must ignore this pop
        task automatic popOnce(input logic frozen);
                @(posedge clk);
                pop <= 1'b1;
                @(posedge clk);
                pop <= 1'b0;                    // Pop taken on this edge
                if (!frozen && modelQ.size() > 0)
                begin
                        expData     = modelQ.pop_front();
                        expOverflow = 1'b0;
                end
                @(negedge clk);
                matchModel();
        endtask

        // One bit time plus 0 to 28 clocks
        task automatic idleGap();
                logic [2:0] r;
                int         gap;
                r = '0;
                for (int k = 0; k < 3; k++)
                begin
                        lfsrState = lfsrStep(lfsrState);
                        r = {r[1:0], lfsrState[0]};
                end
                gap = bitClks + 4 * int'(r);
                repeat (gap) @(posedge clk);
        endtask

        task automatic applyRow(input int i);
                stimRow_t r;
                r = rows[i];
                sendFrame(r.data, r.badStop, r.badPar);
                @(negedge clk);                 // Byte written by now
                expFrameErrs += int'(r.badStop);
                expParErrs   += int'(r.badPar);
                if (!r.badStop && !r.badPar)
                begin
                        if (modelQ.size() == entries)
                                expOverflow = 1'b1;     // Lost byte
                        else
                                modelQ.push_back(r.data);
                end
                tallyErrPulses();
                matchModel();
                repeat (int'(r.pops)) popOnce(1'b0);
                idleGap();
        endtask

        //////////////////////////////////////////////////
        // Stimulus table: data, bad stop, bad parity, pops

        task automatic fillTable();
                rows[0]  = '{8'h3C, 1'b0, 1'b0, 5'd1};
                rows[1]  = '{8'hA5, 1'b1, 1'b0, 5'd0};     // Low stop bit
                rows[2]  = '{8'h96, 1'b0, 1'b1, 5'd1};     // Wrong parity, pop on empty
                rows[3]  = '{8'h01, 1'b0, 1'b0, 5'd0};
                rows[4]  = '{8'h12, 1'b0, 1'b0, 5'd0};
                rows[5]  = '{8'h23, 1'b0, 1'b0, 5'd0};
                rows[6]  = '{8'h34, 1'b0, 1'b0, 5'd0};
                rows[7]  = '{8'h45, 1'b0, 1'b0, 5'd0};
                rows[8]  = '{8'h56, 1'b0, 1'b0, 5'd0};
                rows[9]  = '{8'h67, 1'b0, 1'b0, 5'd0};
                rows[10] = '{8'h78, 1'b0, 1'b0, 5'd0};     // Eighth byte, half full
                rows[11] = '{8'h89, 1'b0, 1'b0, 5'd0};
                rows[12] = '{8'h9A, 1'b0, 1'b0, 5'd0};
                rows[13] = '{8'hAB, 1'b0, 1'b0, 5'd0};
                rows[14] = '{8'hBC, 1'b0, 1'b0, 5'd0};
                rows[15] = '{8'hCD, 1'b0, 1'b0, 5'd0};
                rows[16] = '{8'hDE, 1'b0, 1'b0, 5'd0};
                rows[17] = '{8'hEF, 1'b0, 1'b0, 5'd0};
                rows[18] = '{8'hF0, 1'b0, 1'b0, 5'd0};     // Sixteenth byte, full
                rows[19] = '{8'h5F, 1'b0, 1'b0, 5'd14};    // Overflow, then drain most
                rows[20] = '{8'hC3, 1'b0, 1'b0, 5'd4};     // After self-test
        endtask

        initial
        begin
                rst          <= 1'b1;
                rxLine       <= 1'b1;
                pop          <= 1'b0;
                bistMode     <= 1'b0;
                lfsrState    = 32'ha540;
                expData      = '0;
                expOverflow  = 1'b0;
                expFrameErrs = 0;
                expParErrs   = 0;
                fillTable();

                repeat (8) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);
                matchModel();
                checkValue("bistDone", 32'(bistDone), 32'd0);
                checkValue("bistPass", 32'(bistPass), 32'd0);
                tallyErrPulses();

                for (int i = 0; i < preRows; i++)
                        applyRow(i);

                //////////////////////////////////////////////////
                // Self-test, FIFO frozen

                @(posedge clk);
                bistMode <= 1'b1;
                sendFrame(8'h77, 1'b0, 1'b0);   // Ignored on rxLine
                popOnce(1'b1);
                popOnce(1'b1);
                tallyErrPulses();
                while (!bistDone)
                        @(negedge clk);
                checkValue("bistPass", 32'(bistPass), 32'd1);
                matchModel();
                tallyErrPulses();

                @(posedge clk);
                bistMode <= 1'b0;
                @(negedge clk);
                checkValue("bistDone", 32'(bistDone), 32'd1);  // Still held
                @(negedge clk);
                checkValue("bistDone", 32'(bistDone), 32'd0);
                checkValue("bistPass", 32'(bistPass), 32'd0);
                matchModel();
                idleGap();

                // Reception resumes on the kept contents
                for (int i = preRows; i < numRows; i++)
                        applyRow(i);

                $display("*** PASSED ***");
                $finish;
        end

endmodule

/* sim.f */
logic/uartPkg.sv
logic/rxByteIf.sv
logic/baudTicker.sv
logic/uartRx.sv
logic/rxFifo.sv
logic/bistEngine.sv
logic/uartRxTop.sv
testbench/uartRxTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module uartRxTb -o uartRxSim -f sim.f

simOut=$(./obj_dir/uartRxSim)
echo "$simOut"

echo "$simOut" | grep -qF '*** PASSED ***'
